/* common/vc_consts.svh */
`ifndef VC_CONSTS_SVH
`define VC_CONSTS_SVH

// cache geometry
`define VC_WAYS 8
`define VC_SETS 16
`define VC_IDX_W 4

// line address splits into tag and set index
`define VC_ADDR_W 32
`define VC_TAG_W 28

// one word stands for the whole line
`define VC_DATA_W 32

// AXI4-Lite bus widths
`define VC_AXIL_ADDR_W 32
`define VC_AXIL_DATA_W 32

// register byte offsets
`define VC_CSR_CTRL 32'h0000_0000
`define VC_CSR_HITS 32'h0000_0004
`define VC_CSR_MISSES 32'h0000_0008
`define VC_CSR_EVICTS 32'h0000_000C

`endif

/* common/vc_cache_pkg.sv */
`default_nettype none
`include "vc_consts.svh"

package vc_cache_pkg;

    // operation carried by a cache request
    typedef enum logic {
        VC_OP_LOOKUP = 1'b0,
        VC_OP_INSERT = 1'b1
    } vc_op_e;

    // way number inside a set
    typedef logic [$clog2(`VC_WAYS)-1:0] vc_way_t;

    // request from the first-level cache, 66 bits
    typedef struct packed {
        logic                  valid;
        vc_op_e                op;
        logic [`VC_ADDR_W-1:0] addr;
        logic [`VC_DATA_W-1:0] data;
    } vc_req_t;

    // registered response, one cycle after the request
    typedef struct packed {
        logic                  valid;
        logic                  hit;
        logic [`VC_DATA_W-1:0] data;
        // line pushed out by an insert into a full set
        logic                  evict;
        logic [`VC_ADDR_W-1:0] evict_addr;
        logic [`VC_DATA_W-1:0] evict_data;
    } vc_rsp_t;

    // single-cycle pulses toward the counters
    typedef struct packed {
        logic hit;
        logic miss;
        logic evict;
    } vc_event_t;

endpackage

`default_nettype wire

/* common/vc_axil_pkg.sv */
`default_nettype none
`include "vc_consts.svh"

package vc_axil_pkg;

    // standard AXI response codes
    typedef enum logic [1:0] {
        AXIL_OKAY   = 2'b00,
        AXIL_EXOKAY = 2'b01,
        AXIL_SLVERR = 2'b10,
        AXIL_DECERR = 2'b11
    } axil_resp_e;

    // write address
    typedef struct packed {
        logic [`VC_AXIL_ADDR_W-1:0] addr;
        logic                       valid;
    } axil_aw_t;

    // write data
    typedef struct packed {
        logic [`VC_AXIL_DATA_W-1:0]   data;
        logic [`VC_AXIL_DATA_W/8-1:0] strb;
        logic                         valid;
    } axil_w_t;

    // write response
    typedef struct packed {
        axil_resp_e resp;
        logic       valid;
    } axil_b_t;

    // read address
    typedef struct packed {
        logic [`VC_AXIL_ADDR_W-1:0] addr;
        logic                       valid;
    } axil_ar_t;

    // read data
    typedef struct packed {
        logic [`VC_AXIL_DATA_W-1:0] data;
        axil_resp_e                 resp;
        logic                       valid;
    } axil_r_t;

    // master side
    typedef struct packed {
        axil_aw_t aw;
        axil_w_t  w;
        axil_ar_t ar;
        logic     bready;
        logic     rready;
    } axil_req_t;

    // slave side
    typedef struct packed {
        axil_b_t b;
        axil_r_t r;
        logic    awready;
        logic    wready;
        logic    arready;
    } axil_rsp_t;

endpackage

`default_nettype wire

/* victim_cache/vc_plru.sv */
`default_nettype none
`include "vc_consts.svh"

module vc_plru (
    input  wire                    clk_i,
    input  wire                    rst_ni,
    input  wire [`VC_IDX_W-1:0]    index_i,
    input  wire                    touch_i,
    input  wire vc_cache_pkg::vc_way_t touch_way_i,
    input  wire                    flush_i,
    output vc_cache_pkg::vc_way_t  victim_way_o
);

    // tree nodes per set
    //   L0 picks the half, L1/L2 the quarter, L3..L6 the way
    // a node bit holds the direction of the last touch
    localparam int NODES = 7;

    logic [NODES-1:0] node_we;
    logic [NODES-1:0] node_val;
    logic [NODES-1:0] node_rd;
    vc_cache_pkg::vc_way_t victim;

    // which nodes sit on the path of the touched way
    always_comb begin
        node_we  = '0;
        node_val = '0;
        // root always on the path
        node_we[0]  = touch_i;
        node_val[0] = touch_way_i[2];
        // middle level, left or right by bit 2
        node_we[1]  = touch_i && !touch_way_i[2];
        node_we[2]  = touch_i && touch_way_i[2];
        node_val[1] = touch_way_i[1];
        node_val[2] = touch_way_i[1];
        // leaf chosen by bits 2 and 1
        for (int k = 0; k < 4; k++) begin
            node_we[3+k]  = touch_i && (touch_way_i[2:1] == 2'(k));
            node_val[3+k] = touch_way_i[0];
        end
    end

    // one bit per set for each node
    for (genvar n = 0; n < NODES; n++) begin : g_node
        logic [`VC_SETS-1:0] bits_q;

        always_ff @(posedge clk_i) begin
            if (!rst_ni || flush_i) begin
                bits_q <= '0;
            end else if (node_we[n]) begin
                bits_q[index_i] <= node_val[n];
            end
        end

        // node value for the set being addressed
        assign node_rd[n] = bits_q[index_i];
    end

    // walk away from the recent side at every level
    always_comb begin
        victim[2] = ~node_rd[0];
        victim[1] = victim[2] ? ~node_rd[2] : ~node_rd[1];
        victim[0] = ~node_rd[3 + {victim[2], victim[1]}];
    end

    assign victim_way_o = victim;

    // store must never touch with an undefined way
    a_touch_known: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        touch_i |-> !$isunknown(touch_way_i)
    );

endmodule

`default_nettype wire

/* victim_cache/vc_store.sv */
`default_nettype none
`include "vc_consts.svh"

module vc_store (
    input  wire                        clk_i,
    input  wire                        rst_ni,
    input  wire vc_cache_pkg::vc_req_t req_i,
    input  wire                        enable_i,
    input  wire                        flush_i,
    input  wire vc_cache_pkg::vc_way_t victim_way_i,
    output vc_cache_pkg::vc_rsp_t      rsp_o,
    output logic [`VC_IDX_W-1:0]       index_o,
    output logic                       touch_o,
    output vc_cache_pkg::vc_way_t      touch_way_o,
    output vc_cache_pkg::vc_event_t    event_o
);

    // arrays indexed by set, then way
    logic [`VC_WAYS-1:0]   valid_q [`VC_SETS];
    logic [`VC_TAG_W-1:0]  tag_q   [`VC_SETS][`VC_WAYS];
    logic [`VC_DATA_W-1:0] data_q  [`VC_SETS][`VC_WAYS];

    logic [`VC_IDX_W-1:0]  idx;
    logic [`VC_TAG_W-1:0]  tag;
    logic [`VC_WAYS-1:0]   hit_vec;
    logic                  hit_any;
    logic                  free_any;
    vc_cache_pkg::vc_way_t hit_way;
    vc_cache_pkg::vc_way_t free_way;
    vc_cache_pkg::vc_way_t ins_way;
    logic                  ins_evict;
    logic                  do_lookup;
    logic                  do_insert;

    vc_cache_pkg::vc_rsp_t   rsp_q;
    vc_cache_pkg::vc_event_t event_q;

    // line address is tag above index
    assign idx = req_i.addr[`VC_IDX_W-1:0];
    assign tag = req_i.addr[`VC_ADDR_W-1:`VC_IDX_W];

    // disabled cache ignores everything
    assign do_lookup = req_i.valid && enable_i && (req_i.op == vc_cache_pkg::VC_OP_LOOKUP);
    assign do_insert = req_i.valid && enable_i && (req_i.op == vc_cache_pkg::VC_OP_INSERT);

    // tag compare across all ways of the set
    always_comb begin
        for (int w = 0; w < `VC_WAYS; w++) begin
            hit_vec[w] = valid_q[idx][w] && (tag_q[idx][w] == tag);
        end
    end

    // lowest matching way and lowest free way
    always_comb begin
        hit_way  = '0;
        free_way = '0;
        for (int w = `VC_WAYS - 1; w >= 0; w--) begin
            if (hit_vec[w]) begin
                hit_way = vc_cache_pkg::vc_way_t'(w);
            end
            if (!valid_q[idx][w]) begin
                free_way = vc_cache_pkg::vc_way_t'(w);
            end
        end
        hit_any  = |hit_vec;
        free_any = ~&valid_q[idx];
    end

    // insert target: resident line, then a hole, then the LRU victim
    always_comb begin
        ins_evict = 1'b0;
        if (hit_any) begin
            ins_way = hit_way;
        end else if (free_any) begin
            ins_way = free_way;
        end else begin
            ins_way   = victim_way_i;
            ins_evict = 1'b1;
        end
    end

    // valid bits, flush wins over a same-cycle update
    always_ff @(posedge clk_i) begin
        if (!rst_ni || flush_i) begin
            valid_q <= '{default: '0};
        end else if (do_lookup && hit_any) begin
            // hit hands the line back, so it leaves here
            valid_q[idx][hit_way] <= 1'b0;
        end else if (do_insert) begin
            valid_q[idx][ins_way] <= 1'b1;
        end
    end

    // tag and data payload
    always_ff @(posedge clk_i) begin
        if (do_insert) begin
            tag_q[idx][ins_way]  <= tag;
            data_q[idx][ins_way] <= req_i.data;
        end
    end

    // response and event stage
    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            rsp_q.valid   <= 1'b0;
            rsp_q.hit     <= 1'b0;
            rsp_q.evict   <= 1'b0;
            event_q       <= '0;
        end else begin
            rsp_q.valid   <= req_i.valid;
            rsp_q.hit     <= do_lookup && hit_any;
            rsp_q.evict   <= do_insert && ins_evict;
            event_q.hit   <= do_lookup && hit_any;
            event_q.miss  <= do_lookup && !hit_any;
            event_q.evict <= do_insert && ins_evict;
        end
    end

    // response payload, old line read before the overwrite
    always_ff @(posedge clk_i) begin
        rsp_q.data       <= data_q[idx][hit_way];
        rsp_q.evict_addr <= {tag_q[idx][victim_way_i], idx};
        rsp_q.evict_data <= data_q[idx][victim_way_i];
    end

    assign rsp_o       = rsp_q;
    assign event_o     = event_q;

    // only inserts refresh the replacement order
    assign index_o     = idx;
    assign touch_o     = do_insert;
    assign touch_way_o = ins_way;

    // insert reuses a matching way, so a tag lives in one way at most
    a_one_match: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        req_i.valid |-> $onehot0(hit_vec)
    );

endmodule

`default_nettype wire

/* source/vc_csr_axil.sv */
`default_nettype none
`include "vc_consts.svh"

module vc_csr_axil (
    input  wire                          clk_i,
    input  wire                          rst_ni,
    input  wire vc_axil_pkg::axil_req_t  axil_req_i,
    output vc_axil_pkg::axil_rsp_t       axil_rsp_o,
    input  wire vc_cache_pkg::vc_event_t event_i,
    output logic                         enable_o,
    output logic                         flush_o
);

    // counter order is hits, misses, evicts
    localparam int N_CNT = 3;
    localparam logic [`VC_AXIL_ADDR_W-1:0] CNT_OFS [N_CNT] = '{
        `VC_CSR_HITS, `VC_CSR_MISSES, `VC_CSR_EVICTS
    };

    logic                       enable_q;
    logic                       flush_q;
    logic [31:0]                cnt_q [N_CNT];
    logic [N_CNT-1:0]           ev_vec;

    logic                       wr_fire;
    logic                       rd_fire;
    logic [`VC_AXIL_ADDR_W-1:0] wr_addr;
    logic                       wr_ctrl;
    logic                       wr_err;
    logic [`VC_AXIL_DATA_W-1:0] rd_data;
    logic                       rd_err;

    logic                       bvalid_q;
    vc_axil_pkg::axil_resp_e    bresp_q;
    logic                       rvalid_q;
    logic [`VC_AXIL_DATA_W-1:0] rdata_q;
    vc_axil_pkg::axil_resp_e    rresp_q;

    // write needs both channels and a free B slot
    assign wr_fire = axil_req_i.aw.valid && axil_req_i.w.valid && !bvalid_q;
    assign rd_fire = axil_req_i.ar.valid && !rvalid_q;
    assign wr_addr = axil_req_i.aw.addr;
    assign wr_ctrl = wr_fire && (wr_addr == `VC_CSR_CTRL) && axil_req_i.w.strb[0];

    assign ev_vec  = {event_i.evict, event_i.miss, event_i.hit};

    // write decode, anything off the map is an error
    always_comb begin
        wr_err = 1'b1;
        if (wr_addr == `VC_CSR_CTRL) begin
            wr_err = 1'b0;
        end
        for (int i = 0; i < N_CNT; i++) begin
            if (wr_addr == CNT_OFS[i]) begin
                wr_err = 1'b0;
            end
        end
    end

    // control bits
    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            enable_q <= 1'b1;
            flush_q  <= 1'b0;
        end else begin
            // flush lasts exactly one cycle
            flush_q <= wr_ctrl && axil_req_i.w.data[1];
            if (wr_ctrl) begin
                enable_q <= axil_req_i.w.data[0];
            end
        end
    end

    // event counters, a write clears and beats the increment
    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            cnt_q <= '{default: '0};
        end else begin
            for (int i = 0; i < N_CNT; i++) begin
                if (wr_fire && (wr_addr == CNT_OFS[i])) begin
                    cnt_q[i] <= '0;
                end else if (ev_vec[i]) begin
                    cnt_q[i] <= cnt_q[i] + 32'd1;
                end
            end
        end
    end

    // read mux, flush bit reads back as zero
    always_comb begin
        rd_data = '0;
        rd_err  = 1'b0;
        case (axil_req_i.ar.addr)
            `VC_CSR_CTRL:   rd_data = {31'd0, enable_q};
            `VC_CSR_HITS:   rd_data = cnt_q[0];
            `VC_CSR_MISSES: rd_data = cnt_q[1];
            `VC_CSR_EVICTS: rd_data = cnt_q[2];
            default:        rd_err  = 1'b1;
        endcase
    end

    // B and R valid, held until taken
    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            bvalid_q <= 1'b0;
            rvalid_q <= 1'b0;
        end else begin
            if (wr_fire) begin
                bvalid_q <= 1'b1;
            end else if (axil_req_i.bready) begin
                bvalid_q <= 1'b0;
            end
            if (rd_fire) begin
                rvalid_q <= 1'b1;
            end else if (axil_req_i.rready) begin
                rvalid_q <= 1'b0;
            end
        end
    end

    // response payloads captured at acceptance
    always_ff @(posedge clk_i) begin
        if (wr_fire) begin
            bresp_q <= wr_err ? vc_axil_pkg::AXIL_SLVERR : vc_axil_pkg::AXIL_OKAY;
        end
        if (rd_fire) begin
            rdata_q <= rd_data;
            rresp_q <= rd_err ? vc_axil_pkg::AXIL_SLVERR : vc_axil_pkg::AXIL_OKAY;
        end
    end

    // ready pulses in the accepting cycle
    assign axil_rsp_o.awready = wr_fire;
    assign axil_rsp_o.wready  = wr_fire;
    assign axil_rsp_o.arready = rd_fire;
    assign axil_rsp_o.b.valid = bvalid_q;
    assign axil_rsp_o.b.resp  = bresp_q;
    assign axil_rsp_o.r.valid = rvalid_q;
    assign axil_rsp_o.r.data  = rdata_q;
    assign axil_rsp_o.r.resp  = rresp_q;

    assign enable_o = enable_q;
    assign flush_o  = flush_q;

    // B channel must not drop before the master takes it
    a_b_hold: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        bvalid_q && !axil_req_i.bready |=> bvalid_q
    );

endmodule

`default_nettype wire

/* source/vc_top.sv */
`default_nettype none
`include "vc_consts.svh"

module vc_top (
    input  wire                         clk_i,
    input  wire                         rst_ni,
    input  wire vc_cache_pkg::vc_req_t  cache_req_i,
    output vc_cache_pkg::vc_rsp_t       cache_rsp_o,
    input  wire vc_axil_pkg::axil_req_t axil_req_i,
    output vc_axil_pkg::axil_rsp_t      axil_rsp_o
);

    // control from the register block
    logic enable;
    logic flush;

    // store to replacement state
    logic [`VC_IDX_W-1:0]    plru_index;
    logic                    plru_touch;
    vc_cache_pkg::vc_way_t   plru_touch_way;
    vc_cache_pkg::vc_way_t   plru_victim;

    // outcomes back to the counters
    vc_cache_pkg::vc_event_t cache_event;

    vc_csr_axil u_csr (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .axil_req_i (axil_req_i),
        .axil_rsp_o (axil_rsp_o),
        .event_i    (cache_event),
        .enable_o   (enable),
        .flush_o    (flush)
    );

    vc_store u_store (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .req_i        (cache_req_i),
        .enable_i     (enable),
        .flush_i      (flush),
        .victim_way_i (plru_victim),
        .rsp_o        (cache_rsp_o),
        .index_o      (plru_index),
        .touch_o      (plru_touch),
        .touch_way_o  (plru_touch_way),
        .event_o      (cache_event)
    );

    vc_plru u_plru (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .index_i      (plru_index),
        .touch_i      (plru_touch),
        .touch_way_i  (plru_touch_way),
        .flush_i      (flush),
        .victim_way_o (plru_victim)
    );

endmodule

`default_nettype wire

/* verification/tb_vc_top.sv */
`default_nettype none

module tb_vc_top;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int MAX_VEC = 128;

    logic clk_i;
    logic rst_ni;

    vc_cache_pkg::vc_req_t  cache_req;
    vc_cache_pkg::vc_rsp_t  cache_rsp;
    vc_axil_pkg::axil_req_t axil_req;
    vc_axil_pkg::axil_rsp_t axil_rsp;

    // one entry per vector line
    byte         vec_op    [MAX_VEC];
    logic [31:0] vec_addr  [MAX_VEC];
    logic [31:0] vec_data  [MAX_VEC];
    // hit for cache ops, response code for register ops
    logic [31:0] exp_flag  [MAX_VEC];
    logic [31:0] exp_word  [MAX_VEC];
    logic [31:0] exp_evict [MAX_VEC];
    logic [31:0] exp_eaddr [MAX_VEC];
    logic [31:0] exp_edata [MAX_VEC];

    int n_vec       = 0;
    int n_checks    = 0;
    int n_errors    = 0;
    int cycles      = 0;
    int cycle_limit = 100;

    vc_top u_dut (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .cache_req_i (cache_req),
        .cache_rsp_o (cache_rsp),
        .axil_req_i  (axil_req),
        .axil_rsp_o  (axil_rsp)
    );

    // 4 ns clock
    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    // run limit, scaled by the vector count once loaded
    always @(posedge clk_i) begin
        cycles = cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("timeout after %0d cycles, DUT stopped responding", cycles);
            $display("checks: %0d, errors: %0d", n_checks, n_errors);
            $display("TB FAILED");
            $finish;
        end
    end

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        n_errors++;
        $display("CHECK FAILED at %0t: %s expected %h got %h", $time, name, expected, actual);
    endtask

    // comment lines start with '#'
    task automatic load_vectors();
        int fd;
        int n;
        string tok;
        logic [8*160-1:0] rest;
        fd = $fopen("verification/vc_vectors.txt", "r");
        if (fd == 0) begin
            $display("cannot open verification/vc_vectors.txt");
            n_errors++;
            return;
        end
        while (!$feof(fd) && n_vec < MAX_VEC) begin
            n = $fscanf(fd, "%s", tok);
            if (n == 1 && tok.getc(0) == "#") begin
                n = $fgets(rest, fd);
            end else if (n == 1) begin
                vec_op[n_vec] = tok.getc(0);
                n = $fscanf(fd, "%h %h %h %h %h %h %h", vec_addr[n_vec], vec_data[n_vec],
                            exp_flag[n_vec], exp_word[n_vec], exp_evict[n_vec],
                            exp_eaddr[n_vec], exp_edata[n_vec]);
                if (n == 7) begin
                    n_vec++;
                end else begin
                    $display("malformed vector line after entry %0d", n_vec);
                    n_errors++;
                end
            end
        end
        $fclose(fd);
    endtask

    // one request, response checked one cycle later
    task automatic cache_op(input int i);
        @(posedge clk_i);
        cache_req.valid <= 1'b1;
        cache_req.op    <= (vec_op[i] == "I") ? vc_cache_pkg::VC_OP_INSERT
                                              : vc_cache_pkg::VC_OP_LOOKUP;
        cache_req.addr  <= vec_addr[i];
        cache_req.data  <= vec_data[i];
        @(posedge clk_i);
        cache_req.valid <= 1'b0;
        // registered response is settled mid-cycle
        @(negedge clk_i);
        n_checks++;
        if (cache_rsp.valid !== 1'b1) begin
            report_mismatch("cache_rsp_o.valid", 32'd1, 32'(cache_rsp.valid));
        end
        if (vec_op[i] == "L") begin
            if (cache_rsp.hit !== exp_flag[i][0]) begin
                report_mismatch("cache_rsp_o.hit", exp_flag[i], 32'(cache_rsp.hit));
            end
            // data only means something on a hit
            if (exp_flag[i][0] && cache_rsp.data !== exp_word[i]) begin
                report_mismatch("cache_rsp_o.data", exp_word[i], cache_rsp.data);
            end
        end else begin
            if (cache_rsp.evict !== exp_evict[i][0]) begin
                report_mismatch("cache_rsp_o.evict", exp_evict[i], 32'(cache_rsp.evict));
            end
            if (exp_evict[i][0] && cache_rsp.evict_addr !== exp_eaddr[i]) begin
                report_mismatch("cache_rsp_o.evict_addr", exp_eaddr[i], cache_rsp.evict_addr);
            end
            if (exp_evict[i][0] && cache_rsp.evict_data !== exp_edata[i]) begin
                report_mismatch("cache_rsp_o.evict_data", exp_edata[i], cache_rsp.evict_data);
            end
        end
    endtask

    // AW and W together, then wait for B
    task automatic reg_write(input int i);
        @(posedge clk_i);
        axil_req.aw.addr  <= vec_addr[i];
        axil_req.aw.valid <= 1'b1;
        axil_req.w.data   <= vec_data[i];
        axil_req.w.strb   <= 4'hf;
        axil_req.w.valid  <= 1'b1;
        axil_req.bready   <= 1'b1;
        @(negedge clk_i);
        while (!(axil_rsp.awready && axil_rsp.wready)) @(negedge clk_i);
        @(posedge clk_i);
        axil_req.aw.valid <= 1'b0;
        axil_req.w.valid  <= 1'b0;
        @(negedge clk_i);
        while (!axil_rsp.b.valid) @(negedge clk_i);
        n_checks++;
        if (axil_rsp.b.resp !== exp_flag[i][1:0]) begin
            report_mismatch("axil_rsp_o.b.resp", exp_flag[i], 32'(axil_rsp.b.resp));
        end
        @(posedge clk_i);
        axil_req.bready <= 1'b0;
    endtask

    // AR, then wait for R
    task automatic reg_read(input int i);
        @(posedge clk_i);
        axil_req.ar.addr  <= vec_addr[i];
        axil_req.ar.valid <= 1'b1;
        axil_req.rready   <= 1'b1;
        @(negedge clk_i);
        while (!axil_rsp.arready) @(negedge clk_i);
        @(posedge clk_i);
        axil_req.ar.valid <= 1'b0;
        @(negedge clk_i);
        while (!axil_rsp.r.valid) @(negedge clk_i);
        n_checks++;
        if (axil_rsp.r.resp !== exp_flag[i][1:0]) begin
            report_mismatch("axil_rsp_o.r.resp", exp_flag[i], 32'(axil_rsp.r.resp));
        end
        if (axil_rsp.r.data !== exp_word[i]) begin
            report_mismatch("axil_rsp_o.r.data", exp_word[i], axil_rsp.r.data);
        end
        @(posedge clk_i);
        axil_req.rready <= 1'b0;
    endtask

    initial begin
        // all inputs idle from time zero
        rst_ni    = 1'b0;
        cache_req = '0;
        axil_req  = '0;
        load_vectors();
        cycle_limit = 20 * n_vec + 100;
        repeat (8) @(posedge clk_i);
        rst_ni <= 1'b1;
        for (int i = 0; i < n_vec; i++) begin
            case (vec_op[i])
                "L", "I": cache_op(i);
                "W":      reg_write(i);
                "R":      reg_read(i);
                default: begin
                    $display("unknown operation in vector %0d", i);
                    n_errors++;
                end
            endcase
        end
        repeat (2) @(posedge clk_i);
        $display("checks: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0 && n_vec > 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verification/vc_vectors.txt */
# op addr data flag word evict evict_addr evict_data, all hex; L lookup, I insert, W/R register
# L/I: flag is the hit, word the read data; W/R: flag is the AXI response, word the read data
I 00000105 aaaa0001 0 0 0 0 0
L 00000105 00000000 1 aaaa0001 0 0 0
L 00000105 00000000 0 0 0 0 0
I 00000013 0000d001 0 0 0 0 0
I 00000023 0000d002 0 0 0 0 0
I 00000033 0000d003 0 0 0 0 0
I 00000043 0000d004 0 0 0 0 0
I 00000053 0000d005 0 0 0 0 0
I 00000063 0000d006 0 0 0 0 0
I 00000073 0000d007 0 0 0 0 0
I 00000083 0000d008 0 0 0 0 0
I 00000093 0000d009 0 0 1 00000013 0000d001
I 000000a3 0000d00a 0 0 1 00000053 0000d005
I 000000b3 0000d00b 0 0 1 00000033 0000d003
I 00000093 0000e009 0 0 0 0 0
L 00000093 00000000 1 0000e009 0 0 0
R 00000004 00000000 0 00000002 0 0 0
R 00000008 00000000 0 00000001 0 0 0
R 0000000c 00000000 0 00000003 0 0 0
W 00000004 00000000 0 0 0 0 0
R 00000004 00000000 0 00000000 0 0 0
R 00000010 00000000 2 00000000 0 0 0
W 00000014 00000000 2 0 0 0 0
W 00000000 00000003 0 0 0 0 0
L 00000023 00000000 0 0 0 0 0
L 000000a3 00000000 0 0 0 0 0
I 00001003 0000c001 0 0 0 0 0
I 00001013 0000c002 0 0 0 0 0
I 00001023 0000c003 0 0 0 0 0
I 00001033 0000c004 0 0 0 0 0
I 00001043 0000c005 0 0 0 0 0
I 00001053 0000c006 0 0 0 0 0
I 00001063 0000c007 0 0 0 0 0
I 00001073 0000c008 0 0 0 0 0
I 00001083 0000c009 0 0 1 00001003 0000c001
W 00000000 00000000 0 0 0 0 0
L 00001013 00000000 0 0 0 0 0
I 00000205 00005555 0 0 0 0 0
W 00000000 00000001 0 0 0 0 0
L 00000205 00000000 0 0 0 0 0
L 00001013 00000000 1 0000c002 0 0 0
R 00000000 00000000 0 00000001 0 0 0
R 00000004 00000000 0 00000001 0 0 0
R 00000008 00000000 0 00000004 0 0 0
R 0000000c 00000000 0 00000004 0 0 0

/* all.f */
+incdir+common
common/vc_cache_pkg.sv
common/vc_axil_pkg.sv
victim_cache/vc_plru.sv
victim_cache/vc_store.sv
source/vc_csr_axil.sv
source/vc_top.sv
verification/tb_vc_top.sv

/* Bender.yml */
package:
  name: victim_cache

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/vc_cache_pkg.sv
      - common/vc_axil_pkg.sv
      - victim_cache/vc_plru.sv
      - victim_cache/vc_store.sv
      - source/vc_csr_axil.sv
      - source/vc_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - verification/tb_vc_top.sv
